// ==== verilog/snes_loader_pkg.sv ====
// Shared types and constants; download addresses are 25-bit byte addresses, masks cover 24 bits
package snes_loader_pkg;

// ========================================
// Constants
// ========================================

// Copier block sits in front of the ROM image
localparam logic [24:0] COPIER_HDR_BYTES = 25'd512;

// Internal header bases; size byte at base, RAM size at base+2
localparam logic [24:0] LOROM_HDR_BASE   = 25'h0007FD6;
localparam logic [24:0] HIROM_HDR_BASE   = 25'h000FFD6;
localparam logic [24:0] EXHIROM_HDR_BASE = 25'h040FFD6;

localparam logic [3:0]  ROM_SIZE_DEFAULT = 4'd12;
localparam logic [23:0] MASK_UNIT        = 24'd1024;

localparam int FILL_ADDR_BITS = 17;
localparam int SECTOR_SHIFT   = 9;

localparam logic [5:0] DL_INDEX_CART = 6'd0;
localparam logic [5:0] DL_INDEX_SPC  = 6'd1;
localparam logic [7:0] DL_INDEX_CODE = 8'd255;

// ========================================
// Types
// ========================================

typedef struct packed {
	logic [24:0] addr;
	logic [15:0] data;
	logic        wr;
} dl_word_t;

typedef enum logic [2:0] {
	HDR_AUTO    = 3'd0,
	HDR_NONE    = 3'd1,
	HDR_LOROM   = 3'd2,
	HDR_HIROM   = 3'd3,
	HDR_EXHIROM = 3'd4
} hdr_mode_e;

typedef enum logic [1:0] {
	REGION_AUTO = 2'd0,
	REGION_NTSC = 2'd1,
	REGION_PAL  = 2'd2
} region_sel_e;

typedef enum logic [1:0] {
	FILL_9966 = 2'd0,
	FILL_00FF = 2'd1,
	FILL_55   = 2'd2,
	FILL_FF   = 2'd3
} fill_pattern_e;

typedef struct packed {
	logic [7:0]  rom_type;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic        pal;
} cart_info_t;

// Big endian values, arranged by the code generator
typedef struct packed {
	logic [31:0] flags;
	logic [31:0] addr;
	logic [31:0] compare;
	logic [31:0] replace;
} cheat_code_t;

typedef struct packed {
	logic [FILL_ADDR_BITS-1:0] addr;
	logic [7:0]                data;
	logic                      we;
} fill_wr_t;

typedef struct packed {
	logic [31:0] lba;
	logic        rd;
	logic        wr;
} sd_req_t;

typedef enum logic [0:0] {
	BK_IDLE = 1'b0,
	BK_BUSY = 1'b1
} bk_state_e;

// Size code to address mask, wraps to all ones above code 13
function automatic logic [23:0] size_to_mask(input logic [3:0] size);
	return (MASK_UNIT << size) - 24'd1;
endfunction

endpackage

// ==== verilog/header_detect.sv ====
// Header words are taken only while cart_dl is high; region override applies between downloads
`timescale 1ns/1ps

module header_detect import snes_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  dl_word_t    dl,
	input  logic        cart_dl,
	input  hdr_mode_e   hdr_mode,
	input  region_sel_e region_sel,
	output cart_info_t  cart_info
);

logic [3:0]  rom_size;
logic [3:0]  ram_size;
logic        rom_region;
logic [3:0]  rom_size_nxt;
logic [3:0]  ram_size_nxt;
logic [7:0]  rom_type_nxt;
logic [24:0] hdr_base;
logic        forced;

// Base of the internal header for the forced modes
always_comb begin
	forced = 1'b1;
	case (hdr_mode)
		HDR_LOROM:   hdr_base = LOROM_HDR_BASE;
		HDR_HIROM:   hdr_base = HIROM_HDR_BASE;
		HDR_EXHIROM: hdr_base = EXHIROM_HDR_BASE;
		default: begin
			forced   = 1'b0;
			hdr_base = LOROM_HDR_BASE;
		end
	endcase
end

// Next sizes and type, so the masks follow on the very next cycle
always_comb begin
	rom_size_nxt = rom_size;
	ram_size_nxt = ram_size;
	rom_type_nxt = cart_info.rom_type;
	if (dl.addr == 25'd0) begin
		rom_size_nxt = ROM_SIZE_DEFAULT;
		ram_size_nxt = 4'd0;
		// Auto mode reads the copier's size byte
		if (hdr_mode == HDR_AUTO && dl.data[7:0] != 8'd0) begin
			{ram_size_nxt, rom_size_nxt} = dl.data[7:0];
		end
		case (hdr_mode)
			HDR_HIROM:   rom_type_nxt = 8'd1;
			HDR_EXHIROM: rom_type_nxt = 8'd2;
			HDR_NONE,
			HDR_LOROM:   rom_type_nxt = 8'd0;
			default:     rom_type_nxt = dl.data[15:8];
		endcase
	end
	if (forced && dl.addr == hdr_base + COPIER_HDR_BYTES) begin
		rom_size_nxt = dl.data[11:8];
	end
	if (forced && dl.addr == hdr_base + COPIER_HDR_BYTES + 25'd2) begin
		ram_size_nxt = dl.data[3:0];
	end
end

always_ff @(posedge clk_sys) begin
	if (RESET) begin
		rom_size   <= ROM_SIZE_DEFAULT;
		ram_size   <= 4'd0;
		rom_region <= 1'b0;
		cart_info  <= '0;
	end else if (cart_dl) begin
		if (dl.wr) begin
			rom_size           <= rom_size_nxt;
			ram_size           <= ram_size_nxt;
			cart_info.rom_type <= rom_type_nxt;
			cart_info.rom_mask <= size_to_mask(rom_size_nxt);
			cart_info.ram_mask <= (ram_size_nxt != 4'd0) ? size_to_mask(ram_size_nxt) : 24'd0;
			if (dl.addr == 25'd2) begin
				rom_region <= dl.data[8];
			end
		end
	end else begin
		// Menu choice wins over the header flag
		case (region_sel)
			REGION_PAL:  cart_info.pal <= 1'b1;
			REGION_NTSC: cart_info.pal <= 1'b0;
			default:     cart_info.pal <= rom_region;
		endcase
	end
end

endmodule

// ==== verilog/cheat_assembler.sv ====
// One code is eight 16-bit words at offsets 0..14; a partial code never raises cheat_valid
`timescale 1ns/1ps

module cheat_assembler import snes_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  dl_word_t    dl,
	input  logic        code_dl,
	output cheat_code_t cheat_code,
	output logic        cheat_valid
);

logic code_wr;

assign code_wr = code_dl & dl.wr;

// Word placement, bottom half before top half
always_ff @(posedge clk_sys) begin
	if (code_wr) begin
		case (dl.addr[3:0])
			4'd0:  cheat_code.flags[15:0]    <= dl.data;
			4'd2:  cheat_code.flags[31:16]   <= dl.data;
			4'd4:  cheat_code.addr[15:0]     <= dl.data;
			4'd6:  cheat_code.addr[31:16]    <= dl.data;
			4'd8:  cheat_code.compare[15:0]  <= dl.data;
			4'd10: cheat_code.compare[31:16] <= dl.data;
			4'd12: cheat_code.replace[15:0]  <= dl.data;
			4'd14: cheat_code.replace[31:16] <= dl.data;
			default: ;
		endcase
	end
end

// Last word clocks the code into the console
always_ff @(posedge clk_sys) begin
	if (RESET) begin
		cheat_valid <= 1'b0;
	end else begin
		cheat_valid <= code_wr && dl.addr[3:0] == 4'd14;
	end
end

endmodule

// ==== verilog/ram_clear.sv ====
// Sweeps all 2^17 WRAM bytes once per download start; a new start during a sweep is ignored
`timescale 1ns/1ps

module ram_clear import snes_loader_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  logic          cart_dl,
	input  fill_pattern_e fill_pattern,
	output fill_wr_t      fill_wr,
	output logic          clearing
);

logic                      cart_dl_d;
logic [FILL_ADDR_BITS-1:0] fill_addr;
logic [7:0]                fill_data;

// ========================================
// Sweep control
// ========================================

always_ff @(posedge clk_sys) begin
	if (RESET) begin
		cart_dl_d <= 1'b0;
		clearing  <= 1'b0;
		fill_addr <= '0;
	end else begin
		cart_dl_d <= cart_dl;
		if (cart_dl && !cart_dl_d) begin
			clearing <= 1'b1;
		end
		// Top address is the last write
		if (&fill_addr) begin
			clearing <= 1'b0;
		end
		fill_addr <= clearing ? fill_addr + 1'b1 : '0;
	end
end

// ========================================
// Power-on patterns
// ========================================

always_comb begin
	case (fill_pattern)
		FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
		FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
		FILL_55:   fill_data = 8'h55;
		default:   fill_data = 8'hFF;
	endcase
end

assign fill_wr.addr = fill_addr;
assign fill_wr.data = fill_data;
assign fill_wr.we   = clearing;

endmodule

// ==== verilog/backup_sequencer.sv ====
// Host must complete each sector with a full rise and fall of sd_ack; no timeout is applied
`timescale 1ns/1ps

module backup_sequencer import snes_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        cart_dl,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_present,
	input  logic [23:0] ram_mask,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        autosave,
	input  logic        osd_status,
	input  logic        bsram_write,
	input  logic        sd_ack,
	output sd_req_t     sd_req,
	output logic        bk_loading,
	output logic        bk_busy,
	output logic        bk_pending
);

bk_state_e   state;
logic        bk_ena;
logic        cart_dl_d;
logic        old_load;
logic        old_save;
logic        old_ack;
logic        save_req;
logic        start_load;
logic        start_save;
logic        start_dl;
logic [31:0] last_lba;

// Autosave fires once the OSD opens with unsaved writes
assign save_req   = bk_save | (bk_pending & osd_status & autosave);
assign start_load = bk_ena & bk_load & ~old_load;
assign start_save = bk_ena & save_req & ~old_save;
assign start_dl   = bk_ena & cart_dl_d & ~cart_dl & img_present;
assign last_lba   = {8'd0, ram_mask} >> SECTOR_SHIFT;
assign bk_busy    = (state == BK_BUSY);

// ========================================
// Enable and pending flag
// ========================================

always_ff @(posedge clk_sys) begin
	if (RESET) begin
		cart_dl_d <= 1'b0;
		bk_ena    <= 1'b0;
	end else begin
		cart_dl_d <= cart_dl;
		if (cart_dl && !cart_dl_d) begin
			bk_ena <= 1'b0;
		end
		// Save image gets mounted while the ROM is still downloading
		if (cart_dl && img_mounted && !img_readonly) begin
			bk_ena <= |ram_mask;
		end
	end
end

always_ff @(posedge clk_sys) begin
	if (RESET) begin
		bk_pending <= 1'b0;
	end else if (bk_ena && !osd_status && bsram_write) begin
		bk_pending <= 1'b1;
	end else if (bk_busy || !bk_ena) begin
		bk_pending <= 1'b0;
	end
end

// ========================================
// Sector load/save FSM
// ========================================

always_ff @(posedge clk_sys) begin
	if (RESET) begin
		state      <= BK_IDLE;
		bk_loading <= 1'b0;
		sd_req     <= '0;
		old_load   <= 1'b0;
		old_save   <= 1'b0;
		old_ack    <= 1'b0;
	end else begin
		old_load <= bk_load;
		old_save <= save_req;
		old_ack  <= sd_ack;

		// Host took the request
		if (!old_ack && sd_ack) begin
			sd_req.rd <= 1'b0;
			sd_req.wr <= 1'b0;
		end

		case (state)
			BK_IDLE: begin
				if (start_load || start_save || start_dl) begin
					state      <= BK_BUSY;
					bk_loading <= start_load | start_dl;
					sd_req.lba <= 32'd0;
					sd_req.rd  <= start_load | start_dl;
					sd_req.wr  <= ~(start_load | start_dl);
				end
			end
			default: begin
				if (old_ack && !sd_ack) begin
					if (sd_req.lba >= last_lba) begin
						state      <= BK_IDLE;
						bk_loading <= 1'b0;
					end else begin
						sd_req.lba <= sd_req.lba + 32'd1;
						sd_req.rd  <= bk_loading;
						sd_req.wr  <= ~bk_loading;
					end
				end
			end
		endcase
	end
end

endmodule

// ==== verilog/snes_cart_loader.sv ====
// All inputs sampled on clk_sys; console_reset lags its sources by one cycle
`timescale 1ns/1ps

module snes_cart_loader import snes_loader_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  dl_word_t      dl,
	input  logic [7:0]    dl_index,
	input  logic          dl_active,
	input  hdr_mode_e     hdr_mode,
	input  region_sel_e   region_sel,
	input  fill_pattern_e fill_pattern,
	input  logic          img_mounted,
	input  logic          img_readonly,
	input  logic          img_present,
	input  logic          bk_load,
	input  logic          bk_save,
	input  logic          autosave,
	input  logic          osd_status,
	input  logic          bsram_write,
	input  logic          sd_ack,
	output cart_info_t    cart_info,
	output cheat_code_t   cheat_code,
	output logic          cheat_valid,
	output fill_wr_t      fill_wr,
	output sd_req_t       sd_req,
	output logic          bk_pending,
	output logic          console_reset,
	output logic          activity
);

logic cart_dl;
logic spc_dl;
logic code_dl;
logic clearing;
logic bk_loading;

// ========================================
// Download index decode
// ========================================

assign cart_dl = dl_active && dl_index[5:0] == DL_INDEX_CART;
assign spc_dl  = dl_active && dl_index[5:0] == DL_INDEX_SPC;
assign code_dl = dl_active && dl_index == DL_INDEX_CODE;

header_detect u_header (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.dl         (dl),
	.cart_dl    (cart_dl),
	.hdr_mode   (hdr_mode),
	.region_sel (region_sel),
	.cart_info  (cart_info)
);

cheat_assembler u_cheat (
	.clk_sys     (clk_sys),
	.RESET       (RESET),
	.dl          (dl),
	.code_dl     (code_dl),
	.cheat_code  (cheat_code),
	.cheat_valid (cheat_valid)
);

ram_clear u_clear (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.cart_dl      (cart_dl),
	.fill_pattern (fill_pattern),
	.fill_wr      (fill_wr),
	.clearing     (clearing)
);

// Busy flag stays internal to the sequencer
backup_sequencer u_backup (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.cart_dl      (cart_dl),
	.img_mounted  (img_mounted),
	.img_readonly (img_readonly),
	.img_present  (img_present),
	.ram_mask     (cart_info.ram_mask),
	.bk_load      (bk_load),
	.bk_save      (bk_save),
	.autosave     (autosave),
	.osd_status   (osd_status),
	.bsram_write  (bsram_write),
	.sd_ack       (sd_ack),
	.sd_req       (sd_req),
	.bk_loading   (bk_loading),
	.bk_busy      (),
	.bk_pending   (bk_pending)
);

// Console held while anything rewrites its memories
always_ff @(posedge clk_sys) begin
	if (RESET) begin
		console_reset <= 1'b1;
	end else begin
		console_reset <= cart_dl | spc_dl | clearing | bk_loading;
	end
end

assign activity = cart_dl | spc_dl | (autosave & bk_pending);

endmodule

// ==== verif/tb_checks.svh ====
// Compare tasks for the loader testbench; cur_test must name the running test before any check
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int    error_count = 0;
int    checks_run  = 0;
string cur_test    = "none";

task automatic check_cart_info(input string what, input cart_info_t exp, input cart_info_t act);
	checks_run++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: %s expected type %h rom %h ram %h pal %b, actual type %h rom %h ram %h pal %b",
			cur_test, what, exp.rom_type, exp.rom_mask, exp.ram_mask, exp.pal,
			act.rom_type, act.rom_mask, act.ram_mask, act.pal);
	end
endtask

task automatic check_cheat(input string what, input cheat_code_t exp, input cheat_code_t act);
	checks_run++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: %s expected %h, actual %h", cur_test, what, exp, act);
	end
endtask

task automatic check_fill(input string what, input fill_wr_t exp, input fill_wr_t act);
	checks_run++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: %s expected addr %h data %h we %b, actual addr %h data %h we %b",
			cur_test, what, exp.addr, exp.data, exp.we, act.addr, act.data, act.we);
	end
endtask

task automatic check_req(input string what, input sd_req_t exp, input sd_req_t act);
	checks_run++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: %s expected lba %0d rd %b wr %b, actual lba %0d rd %b wr %b",
			cur_test, what, exp.lba, exp.rd, exp.wr, act.lba, act.rd, act.wr);
	end
endtask

// Single flags such as console_reset or bk_pending
task automatic check_bit(input string what, input logic exp, input logic act);
	checks_run++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: %s expected %b, actual %b", cur_test, what, exp, act);
	end
endtask

task automatic check_count(input string what, input int exp, input int act);
	checks_run++;
	if (act != exp) begin
		error_count++;
		$display("FAILED %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
	end
endtask

`endif

// ==== verif/tb_snes_cart_loader.sv ====
// Directed tests only; the sector host answers every request with random ack delays
`timescale 1ns/1ps

module tb_snes_cart_loader import snes_loader_pkg::*; ();

logic          clk_sys = 1'b0;
logic          RESET;
dl_word_t      dl;
logic [7:0]    dl_index;
logic          dl_active;
hdr_mode_e     hdr_mode;
region_sel_e   region_sel;
fill_pattern_e fill_pattern;
logic          img_mounted;
logic          img_readonly;
logic          img_present;
logic          bk_load;
logic          bk_save;
logic          autosave;
logic          osd_status;
logic          bsram_write;
logic          sd_ack;
cart_info_t    cart_info;
cheat_code_t   cheat_code;
logic          cheat_valid;
fill_wr_t      fill_wr;
sd_req_t       sd_req;
logic          bk_pending;
logic          console_reset;
logic          activity;

integer seed      = 84;
bit     timed_out = 1'b0;
int     tests_run = 0;
int     test_err_base;

`include "tb_checks.svh"

always #4 clk_sys = ~clk_sys;

snes_cart_loader UUT (.*);

// ========================================
// Helpers
// ========================================

task automatic begin_test(input string name);
	cur_test      = name;
	test_err_base = error_count;
	tests_run++;
endtask

task automatic end_test();
	if (error_count == test_err_base) begin
		$display("test %-14s pass", cur_test);
	end else begin
		$display("test %-14s fail, %0d mismatches", cur_test, error_count - test_err_base);
	end
endtask

task automatic note_timeout(input string what);
	timed_out = 1'b1;
	error_count++;
	$display("Timeout in %s: %s", cur_test, what);
endtask

// One write strobe, taken on the next rising edge
task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
	dl.addr = addr;
	dl.data = data;
	dl.wr   = 1'b1;
	@(negedge clk_sys);
	dl.wr = 1'b0;
endtask

// 1024 bytes times two to the size code, minus one
function automatic logic [23:0] mask_for(input logic [3:0] size);
	int bits;
	bits = 10 + int'(size);
	return (24'd1 << bits) - 24'd1;
endfunction

function automatic logic [7:0] fill_expect(input fill_pattern_e pattern, input logic [16:0] addr);
	case (pattern)
		FILL_9966: return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
		FILL_00FF: return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		FILL_55:   return 8'h55;
		default:   return 8'hFF;
	endcase
endfunction

// Host side of the sector bus
task automatic serve_sectors(input logic read_op, input int sectors);
	sd_req_t exp;
	int      i;
	int      n;
	int      delay;
	for (i = 0; i < sectors; i++) begin
		n = 0;
		while (!(sd_req.rd || sd_req.wr) && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		if (!(sd_req.rd || sd_req.wr)) begin
			note_timeout($sformatf("no request for sector %0d", i));
			return;
		end
		exp.lba = i;
		exp.rd  = read_op;
		exp.wr  = ~read_op;
		check_req($sformatf("request %0d", i), exp, sd_req);
		delay = 1 + ($random(seed) & 7);
		repeat (delay) @(negedge clk_sys);
		sd_ack = 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while ((sd_req.rd || sd_req.wr) && n < 16);
		if (sd_req.rd || sd_req.wr) begin
			note_timeout($sformatf("request %0d kept after sd_ack", i));
			return;
		end
		delay = $random(seed) & 3;
		repeat (delay) @(negedge clk_sys);
		sd_ack = 1'b0;
	end
endtask

task automatic wait_backup_idle(input int last_lba);
	sd_req_t exp;
	int      n;
	n = 0;
	while (UUT.u_backup.bk_busy && n < 16) begin
		@(negedge clk_sys);
		n++;
	end
	if (UUT.u_backup.bk_busy) begin
		note_timeout("bk_busy stayed high after the last sector");
		return;
	end
	exp.lba = last_lba;
	exp.rd  = 1'b0;
	exp.wr  = 1'b0;
	check_req("after last sector", exp, sd_req);
endtask

// ========================================
// Directed tests
// ========================================

task automatic test_reset();
	begin_test("reset");
	check_bit("console_reset", 1'b1, console_reset);
	check_bit("cheat_valid", 1'b0, cheat_valid);
	check_bit("fill we", 1'b0, fill_wr.we);
	check_bit("bk_pending", 1'b0, bk_pending);
	check_req("idle request", '0, sd_req);
	end_test();
endtask

task automatic forced_header_case(input hdr_mode_e mode, input logic [24:0] base,
		input logic [7:0] rtype, input logic [3:0] rom_sz, input logic [3:0] ram_sz);
	cart_info_t exp;
	hdr_mode   = mode;
	region_sel = REGION_NTSC;
	dl_index   = 8'd0;
	dl_active  = 1'b1;
	write_word(25'd0, 16'h0000);
	write_word(base + COPIER_HDR_BYTES, {4'h0, rom_sz, 8'h00});
	write_word(base + COPIER_HDR_BYTES + 25'd2, {12'h000, ram_sz});
	dl_active = 1'b0;
	repeat (2) @(negedge clk_sys);
	exp.rom_type = rtype;
	exp.rom_mask = mask_for(rom_sz);
	exp.ram_mask = mask_for(ram_sz);
	exp.pal      = 1'b0;
	check_cart_info(mode.name(), exp, cart_info);
endtask

task automatic test_forced_header();
	begin_test("forced_header");
	forced_header_case(HDR_LOROM, LOROM_HDR_BASE, 8'd0, 4'd9, 4'd1);
	forced_header_case(HDR_HIROM, HIROM_HDR_BASE, 8'd1, 4'd11, 4'd3);
	forced_header_case(HDR_EXHIROM, EXHIROM_HDR_BASE, 8'd2, 4'd13, 4'd5);
	end_test();
endtask

task automatic test_auto_header();
	cart_info_t exp;
	begin_test("auto_header");
	hdr_mode   = HDR_AUTO;
	region_sel = REGION_AUTO;
	dl_index   = 8'd0;
	dl_active  = 1'b1;
	// Type 35h, RAM size 2, ROM size 11
	write_word(25'd0, 16'h352B);
	exp.rom_type = 8'h35;
	exp.rom_mask = mask_for(4'd11);
	exp.ram_mask = mask_for(4'd2);
	exp.pal      = 1'b0;
	check_cart_info("after word 0", exp, cart_info);
	write_word(25'd2, 16'h0100);
	dl_active = 1'b0;
	repeat (2) @(negedge clk_sys);
	exp.pal = 1'b1;
	check_cart_info("region from header", exp, cart_info);
	region_sel = REGION_NTSC;
	repeat (2) @(negedge clk_sys);
	exp.pal = 1'b0;
	check_cart_info("region forced ntsc", exp, cart_info);
	end_test();
endtask

task automatic test_cheat();
	logic [31:0] rnd;
	logic [15:0] words [8];
	cheat_code_t exp;
	int          pulses;
	int          i;
	begin_test("cheat_code");
	for (i = 0; i < 8; i++) begin
		rnd      = $random(seed);
		words[i] = rnd[15:0];
	end
	exp.flags   = {words[1], words[0]};
	exp.addr    = {words[3], words[2]};
	exp.compare = {words[5], words[4]};
	exp.replace = {words[7], words[6]};
	dl_index  = DL_INDEX_CODE;
	dl_active = 1'b1;
	pulses    = 0;
	for (i = 0; i < 8; i++) begin
		if (cheat_valid) pulses++;
		write_word(25'h0000020 + 25'(2 * i), words[i]);
	end
	dl_active = 1'b0;
	check_bit("cheat_valid after last word", 1'b1, cheat_valid);
	check_cheat("assembled code", exp, cheat_code);
	if (cheat_valid) pulses++;
	repeat (3) begin
		@(negedge clk_sys);
		if (cheat_valid) pulses++;
	end
	check_count("cheat_valid pulses", 1, pulses);
	end_test();
endtask

task automatic fill_sweep(input fill_pattern_e pattern);
	fill_wr_t    exp;
	logic [16:0] addr;
	int          writes;
	int          n;
	n = 0;
	while (fill_wr.we && n < 140000) begin
		@(negedge clk_sys);
		n++;
	end
	if (fill_wr.we) begin
		note_timeout("earlier fill sweep never ended");
		return;
	end
	@(negedge clk_sys);
	check_bit("console_reset before download", 1'b0, console_reset);
	fill_pattern = pattern;
	dl_index     = 8'd0;
	dl_active    = 1'b1;
	@(negedge clk_sys);
	check_bit("console_reset at download start", 1'b1, console_reset);
	check_bit("clearing at download start", 1'b1, fill_wr.we);
	addr   = '0;
	writes = 0;
	while (fill_wr.we && writes < 140000) begin
		exp.addr = addr;
		exp.data = fill_expect(pattern, addr);
		exp.we   = 1'b1;
		check_fill(pattern.name(), exp, fill_wr);
		addr = addr + 17'd1;
		writes++;
		if (writes == 4) dl_active = 1'b0;
		@(negedge clk_sys);
	end
	check_count("fill writes", 1 << FILL_ADDR_BITS, writes);
endtask

task automatic test_fill();
	begin_test("wram_fill");
	fill_sweep(FILL_9966);
	if (!timed_out) fill_sweep(FILL_55);
	end_test();
endtask

task automatic test_backup_load();
	cart_info_t exp;
	int         sectors;
	begin_test("backup_load");
	hdr_mode     = HDR_LOROM;
	img_mounted  = 1'b1;
	img_readonly = 1'b0;
	img_present  = 1'b1;
	dl_index     = 8'd0;
	dl_active    = 1'b1;
	write_word(25'd0, 16'h0000);
	write_word(LOROM_HDR_BASE + COPIER_HDR_BYTES, 16'h0A00);
	write_word(LOROM_HDR_BASE + COPIER_HDR_BYTES + 25'd2, 16'h0003);
	repeat (2) @(negedge clk_sys);
	exp.rom_type = 8'd0;
	exp.rom_mask = mask_for(4'd10);
	exp.ram_mask = 24'h001FFF;
	exp.pal      = 1'b0;
	check_cart_info("save ram header", exp, cart_info);
	// Download end with an image present starts the load
	dl_active = 1'b0;
	sectors = (int'(exp.ram_mask) + 1) >> SECTOR_SHIFT;
	serve_sectors(1'b1, sectors);
	if (!timed_out) wait_backup_idle(sectors - 1);
	img_present = 1'b0;
	end_test();
endtask

task automatic test_autosave();
	int sectors;
	begin_test("autosave");
	// 8 KB save RAM left by the backup load test
	sectors     = 32'h2000 >> SECTOR_SHIFT;
	osd_status  = 1'b0;
	autosave    = 1'b0;
	bsram_write = 1'b1;
	@(negedge clk_sys);
	bsram_write = 1'b0;
	check_bit("bk_pending after write", 1'b1, bk_pending);
	autosave = 1'b1;
	@(negedge clk_sys);
	check_bit("activity while pending", 1'b1, activity);
	osd_status = 1'b1;
	serve_sectors(1'b0, sectors);
	if (!timed_out) wait_backup_idle(sectors - 1);
	check_bit("bk_pending after save", 1'b0, bk_pending);
	osd_status = 1'b0;
	autosave   = 1'b0;
	end_test();
endtask

// ========================================
// Main sequence
// ========================================

initial begin
	RESET        = 1'b1;
	dl           = '0;
	dl_index     = 8'd0;
	dl_active    = 1'b0;
	hdr_mode     = HDR_AUTO;
	region_sel   = REGION_AUTO;
	fill_pattern = FILL_9966;
	img_mounted  = 1'b0;
	img_readonly = 1'b0;
	img_present  = 1'b0;
	bk_load      = 1'b0;
	bk_save      = 1'b0;
	autosave     = 1'b0;
	osd_status   = 1'b0;
	bsram_write  = 1'b0;
	sd_ack       = 1'b0;
	repeat (2) @(negedge clk_sys);
	test_reset();
	RESET = 1'b0;
	@(negedge clk_sys);
	if (!timed_out) test_forced_header();
	if (!timed_out) test_auto_header();
	if (!timed_out) test_cheat();
	if (!timed_out) test_fill();
	if (!timed_out) test_backup_load();
	if (!timed_out) test_autosave();
	$display("%0d tests, %0d checks, %0d errors", tests_run, checks_run, error_count);
	if (error_count == 0) begin
		$display("NO ERRORS");
	end else begin
		$display("ERRORS FOUND");
	end
	$finish;
end

endmodule

// ==== snes_cart_loader.f ====
+incdir+verif
verilog/snes_loader_pkg.sv
verilog/header_detect.sv
verilog/cheat_assembler.sv
verilog/ram_clear.sv
verilog/backup_sequencer.sv
verilog/snes_cart_loader.sv
verif/tb_snes_cart_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_snes_cart_loader

verilator --binary --timing -Wno-fatal \
	-f snes_cart_loader.f \
	--top-module "$TOP" \
	--Mdir "$BUILD_DIR" \
	-o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG_FILE"
	exit 1
fi
